// ==== Makefile ====
TOP = tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir

// ==== dcache_checker.sv ====
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_checker
    import dcache_pkg::*;
(
    input  logic         CLK,
    input  logic         RST,
    input  cpu_req_t     req,
    input  logic         addr_valid,
    input  logic         cache_ready,
    input  word_t        data,
    input  logic         wb_valid,
    input  wb_req_t      wb,
    input  logic [127:0] test_name,
    input  word_t        exp_data,
    input  logic         exp_evict,
    input  logic [31:0]  exp_wb_addr,
    input  word_t        exp_wb_word,
    output int           done_count,
    output int           error_count
);

    logic [127:0] p_name;   // request in flight captured when it is accepted
    op_e          p_op;
    word_t        p_exp;
    logic         p_evict;
    logic [31:0]  p_wb_addr;
    word_t        p_wb_word;
    logic         p_valid;
    logic         p_wb_seen;
    logic         p_bad;
    logic         p_hit;
    int           p_start;
    int           cycle;
    tag_t         line_tag [`DC_LINES];   // tags a direct-mapped cache holds after each access
    logic [`DC_LINES-1:0] line_valid;

    task automatic check_wb();
        word_t got;
        got = wb.data[{p_wb_addr[4:3], 6'd0} +: `DC_WORD_W];   // word the store went to
        if (!p_valid || !p_evict) begin
            $display("unexpected write-back of line %h while no eviction was due", wb.addr);
            error_count++;
        end else begin
            p_wb_seen = 1'b1;
            if (wb.addr !== p_wb_addr[31:5]) begin
                $display("Fail %0s wb address: expected %h, actual %h",
                         p_name, p_wb_addr[31:5], wb.addr);
                p_bad = 1'b1;
            end
            if (got !== p_wb_word) begin
                $display("Fail %0s wb word: expected %h, actual %h", p_name, p_wb_word, got);
                p_bad = 1'b1;
            end
        end
    endtask

    task automatic finish_test();
        if (p_op == op_load && data !== p_exp) begin
            $display("Fail %0s: expected %h, actual %h", p_name, p_exp, data);
            p_bad = 1'b1;
        end
        if (p_evict && !p_wb_seen) begin
            $display("%0s finished but the dirty victim line was never written back", p_name);
            p_bad = 1'b1;
        end
        if (p_hit && cycle - p_start != 1) begin
            $display("%0s should complete one cycle after accept but took %0d cycles",
                     p_name, cycle - p_start);
            p_bad = 1'b1;
        end
        if (p_bad) begin
            error_count++;
        end else begin
            $display("ok   %0s, done %0d cycles after accept", p_name, cycle - p_start);
        end
        done_count++;
        p_valid = 1'b0;
    endtask

    // sampled mid-cycle because acceptance and completion both land on the next rising edge
    always @(negedge CLK) begin
        if (RST) begin
            p_valid     = 1'b0;
            cycle       = 0;
            done_count  = 0;
            error_count = 0;
            line_valid  = '0;
        end else begin
            cycle++;
            if (wb_valid) begin
                check_wb();
            end
            if (p_valid && cache_ready) begin
                finish_test();
            end
            if (addr_valid && cache_ready) begin
                p_name    = test_name;
                p_op      = req.op;
                p_exp     = exp_data;
                p_evict   = exp_evict;
                p_wb_addr = exp_wb_addr;
                p_wb_word = exp_wb_word;
                p_valid   = 1'b1;
                p_wb_seen = 1'b0;
                p_bad     = 1'b0;
                p_start   = cycle;
                p_hit     = 1'b1;
                if (req.op == op_load || req.op == op_store) begin
                    p_hit = line_valid[req.addr.index] &&
                            line_tag[req.addr.index] == req.addr.tag;
                    line_valid[req.addr.index] = 1'b1;
                    line_tag[req.addr.index]   = req.addr.tag;
                end
            end
        end
    end

endmodule

// ==== dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DC_WORD_W   64
`define DC_ADDR_W   32
`define DC_WORDS    4
`define DC_LINES    16

// byte offset inside a line, 5 bits for 4 words of 8 bytes
`define DC_OFFSET_W ($clog2(`DC_WORDS * `DC_WORD_W / 8))

`define DC_INDEX_W  ($clog2(`DC_LINES))

// whatever the address keeps above index and offset
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`define DC_LINE_W   (`DC_WORDS * `DC_WORD_W)

`endif

// ==== dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    // same codes as the core's control field
    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_load  = 2'b01,
        op_store = 2'b10
    } op_e;

    typedef logic [`DC_WORD_W-1:0]               word_t;
    typedef logic [`DC_WORD_W/8-1:0]             strb_t;
    typedef logic [`DC_LINE_W-1:0]               line_t;
    typedef logic [`DC_TAG_W-1:0]                tag_t;
    typedef logic [`DC_INDEX_W-1:0]              index_t;
    typedef logic [`DC_ADDR_W-`DC_OFFSET_W-1:0]  line_addr_t;

    typedef struct packed {
        tag_t                    tag;
        index_t                  index;
        logic [`DC_OFFSET_W-4:0] word_sel;   // word within the line
        logic [2:0]              byte_off;   // ignored, loads and stores are word wide
    } addr_fields_t;

    typedef struct packed {
        op_e          op;
        addr_fields_t addr;
        word_t        wdata;
        strb_t        wstrb;
    } cpu_req_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } wb_req_t;

endpackage

// ==== dcache_testdata.txt ====
# name op addr wdata wstrb expected evict wb_addr wb_word, hex after the name
# op 0 none 1 load 2 store, evict 1 checks the write-back of the line holding wb_addr
cold_load    1 00001040 0000000000000000 00 d00dfeed00001040 0 00000000 0000000000000000
hit_load     1 00001058 0000000000000000 00 d00dfeed00001058 0 00000000 0000000000000000
idle_req     0 00000000 0000000000000000 00 0000000000000000 0 00000000 0000000000000000
st_part      2 00001048 1122334455667788 0f 0000000000000000 0 00000000 0000000000000000
ld_other     1 00001050 0000000000000000 00 d00dfeed00001050 0 00000000 0000000000000000
ld_part      1 00001048 0000000000000000 00 d00dfeed55667788 0 00000000 0000000000000000
st_bypass    2 00001050 aabbccddeeff0011 f0 0000000000000000 0 00000000 0000000000000000
ld_bypass    1 00001050 0000000000000000 00 aabbccdd00001050 0 00000000 0000000000000000
evict_load   1 00003048 0000000000000000 00 d00dfeed00003048 1 00001048 d00dfeed55667788
reload_evict 1 00001048 0000000000000000 00 d00dfeed55667788 0 00000000 0000000000000000
reload_other 1 00001050 0000000000000000 00 aabbccdd00001050 0 00000000 0000000000000000
st_miss      2 00002000 0123456789abcdef ff 0000000000000000 0 00000000 0000000000000000
ld_st_miss   1 00002000 0000000000000000 00 0123456789abcdef 0 00000000 0000000000000000
st_evict     2 00004008 00000000000000ab 01 0000000000000000 1 00002000 0123456789abcdef
ld_st_evict  1 00004008 0000000000000000 00 d00dfeed000040ab 0 00000000 0000000000000000
ld_back      1 00002000 0000000000000000 00 0123456789abcdef 1 00004008 d00dfeed000040ab
ld_pattern   1 00003058 0000000000000000 00 d00dfeed00003058 0 00000000 0000000000000000

// ==== dcache_top.sv ====
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  cpu_req_t   req,
    input  logic       addr_valid,
    output logic       cache_ready,
    output word_t      data,

    output logic       addr_to_l2_valid,
    output line_addr_t addr_to_l2,
    input  line_t      data_from_l2,
    input  logic       data_from_l2_valid,
    output logic       wb_valid,
    output wb_req_t    wb,
    input  logic       write_done
);

    cpu_req_t req_q;
    index_t   rd_index;
    line_t    line_rd;
    tag_t     tag_rd;
    logic     valid_rd;
    logic     dirty_rd;

    logic     wr_q;
    index_t   wr_index_q;
    line_t    wr_line_q;
    logic     wr_dirty_q;
    logic     bypass;
    line_t    cur_line;
    logic     cur_dirty;

    logic     is_load;
    logic     is_store;
    logic     hit;
    logic     miss;
    logic     busy;
    logic     install;
    logic     store_hit;
    logic     data_wren;
    line_t    merge_src;
    line_t    merged;
    line_t    wline;

    // stage register, empties when a request completes and none follows
    always_ff @(posedge CLK) begin
        if (RST) begin
            req_q.op <= op_none;
        end else if (cache_ready) begin
            if (addr_valid) begin
                req_q <= req;
            end else begin
                req_q.op <= op_none;
            end
        end
    end

    assign rd_index = cache_ready ? req.addr.index : req_q.addr.index;

    line_ram #(.WIDTH(`DC_LINE_W), .DEPTH(`DC_LINES)) u_data_ram (
        .CLK(CLK), .wren(data_wren), .waddr(req_q.addr.index), .raddr(rd_index),
        .wdata(wline), .rdata(line_rd));

    line_ram #(.WIDTH(`DC_TAG_W), .DEPTH(`DC_LINES)) u_tag_ram (
        .CLK(CLK), .wren(install), .waddr(req_q.addr.index), .raddr(rd_index),
        .wdata(req_q.addr.tag), .rdata(tag_rd));

    flag_array u_valid (
        .CLK(CLK), .RST(RST), .wren(install), .waddr(req_q.addr.index),
        .wbit(1'b1), .raddr(rd_index), .rbit(valid_rd));

    flag_array u_dirty (
        .CLK(CLK), .RST(RST), .wren(data_wren), .waddr(req_q.addr.index),
        .wbit(is_store), .raddr(rd_index), .rbit(dirty_rd));

    // last write, for a lookup whose read raced it at the same edge
    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= data_wren;
        end
    end

    always_ff @(posedge CLK) begin
        if (data_wren) begin
            wr_index_q <= req_q.addr.index;
            wr_line_q  <= wline;
            wr_dirty_q <= is_store;
        end
    end

    assign bypass    = wr_q && (wr_index_q == req_q.addr.index);
    assign cur_line  = bypass ? wr_line_q : line_rd;
    assign cur_dirty = bypass ? wr_dirty_q : dirty_rd;

    assign is_load   = (req_q.op == op_load);
    assign is_store  = (req_q.op == op_store);
    assign hit       = valid_rd && (tag_rd == req_q.addr.tag);
    assign miss      = (is_load || is_store) && !hit;
    assign store_hit = is_store && hit && !busy;
    assign data_wren = store_hit || install;

    assign cache_ready = !(is_load || is_store) || (hit && !busy);

    // a refill is merged with the pending store before it is written
    assign merge_src = install ? data_from_l2 : cur_line;
    assign wline     = is_store ? merged : merge_src;

    line_merge u_merge (
        .line(merge_src), .word_sel(req_q.addr.word_sel), .wdata(req_q.wdata),
        .wstrb(req_q.wstrb), .word(data), .merged(merged));

    miss_ctrl u_miss_ctrl (
        .CLK(CLK), .RST(RST), .miss(miss), .victim_dirty(valid_rd && cur_dirty),
        .victim_tag(tag_rd), .req(req_q),
        .addr_to_l2_valid(addr_to_l2_valid), .addr_to_l2(addr_to_l2),
        .wb_valid(wb_valid), .wb(wb), .write_done(write_done),
        .data_from_l2_valid(data_from_l2_valid),
        .victim_line(cur_line), .install(install), .busy(busy));

endmodule

// ==== flag_array.sv ====
`timescale 1ns/100ps
`include "dcache_consts.svh"

module flag_array
    import dcache_pkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  logic   wren,
    input  index_t waddr,
    input  logic   wbit,
    input  index_t raddr,
    output logic   rbit
);

    logic [`DC_LINES-1:0] flags;

    always_ff @(posedge CLK) begin
        if (RST) begin
            flags <= '0;
        end else if (wren) begin
            flags[waddr] <= wbit;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rbit <= 1'b0;
        end else begin
            rbit <= flags[raddr];   // read before write, same as line_ram
        end
    end

    a_waddr_known: assert property (@(posedge CLK) disable iff (RST)
        wren |-> !$isunknown(waddr));

endmodule

// ==== line_merge.sv ====
`timescale 1ns/100ps
`include "dcache_consts.svh"

module line_merge
    import dcache_pkg::*;
(
    input  line_t                   line,
    input  logic [`DC_OFFSET_W-4:0] word_sel,
    input  word_t                   wdata,
    input  strb_t                   wstrb,
    output word_t                   word,
    output line_t                   merged
);

    word_t sel_word;
    word_t new_word;

    // addressed word of the line, also the load result
    always_comb begin
        sel_word = line[word_sel*`DC_WORD_W +: `DC_WORD_W];
    end

    always_comb begin
        new_word = sel_word;
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (wstrb[b]) begin
                new_word[b*8 +: 8] = wdata[b*8 +: 8];   // strobed byte comes from the store
            end
        end
    end

    // other words of the line pass through unchanged
    always_comb begin
        merged = line;
        merged[word_sel*`DC_WORD_W +: `DC_WORD_W] = new_word;
    end

    assign word = sel_word;

endmodule

// ==== line_ram.sv ====
`timescale 1ns/100ps

module line_ram #(
    parameter int WIDTH = 256,
    parameter int DEPTH = 16
) (
    input  logic                     CLK,
    input  logic                     wren,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge CLK) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    // a read of the index being written returns the old contents
    always_ff @(posedge CLK) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== miss_ctrl.sv ====
`timescale 1ns/100ps

module miss_ctrl
    import dcache_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       miss,
    input  logic       victim_dirty,
    input  tag_t       victim_tag,
    input  cpu_req_t   req,

    output logic       addr_to_l2_valid,
    output line_addr_t addr_to_l2,
    output logic       wb_valid,
    output wb_req_t    wb,
    input  logic       write_done,
    input  logic       data_from_l2_valid,

    input  line_t      victim_line,
    output logic       install,
    output logic       busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WB_WAIT,
        S_RF_WAIT,
        S_INSTALL
    } state_e;

    state_e state;
    state_e state_nx;
    logic   start_wb;
    logic   start_rf;

    always_comb begin
        state_nx = state;
        start_wb = 1'b0;
        start_rf = 1'b0;
        case (state)
            S_IDLE: begin
                if (miss) begin
                    if (victim_dirty) begin
                        start_wb = 1'b1;
                        state_nx = S_WB_WAIT;
                    end else begin
                        start_rf = 1'b1;
                        state_nx = S_RF_WAIT;
                    end
                end
            end
            S_WB_WAIT: begin
                if (write_done) begin
                    start_rf = 1'b1;   // refill only once L2 has taken the victim
                    state_nx = S_RF_WAIT;
                end
            end
            S_RF_WAIT: begin
                if (data_from_l2_valid) begin
                    state_nx = S_INSTALL;
                end
            end
            default: begin
                state_nx = S_IDLE;   // arrays are re-read with the new line here
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state            <= S_IDLE;
            addr_to_l2_valid <= 1'b0;
            wb_valid         <= 1'b0;
        end else begin
            state            <= state_nx;
            addr_to_l2_valid <= start_rf;
            wb_valid         <= start_wb;
        end
    end

    // victim is captured in the lookup cycle of the miss
    always_ff @(posedge CLK) begin
        if (start_wb) begin
            wb.addr <= {victim_tag, req.addr.index};
            wb.data <= victim_line;
        end
    end

    // the request is held still while the miss is served
    assign addr_to_l2 = {req.addr.tag, req.addr.index};

    assign install = (state == S_RF_WAIT) && data_from_l2_valid;
    assign busy    = (state != S_IDLE);

    a_l2_req_pulse: assert property (@(posedge CLK) disable iff (RST)
        addr_to_l2_valid |=> !addr_to_l2_valid);

    a_no_refill_in_wb: assert property (@(posedge CLK) disable iff (RST)
        (state == S_WB_WAIT) |-> !addr_to_l2_valid);

endmodule

// ==== src.f ====
+incdir+.
dcache_pkg.sv
line_ram.sv
flag_array.sv
line_merge.sv
miss_ctrl.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
`timescale 1ns/100ps
`include "dcache_consts.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          CLK_HALF  = 50;
    localparam int          DRIVE_DLY = 10;
    localparam logic [63:0] PATTERN_KEY = 64'hD00D_FEED_0000_0000;

    typedef struct packed {
        logic [127:0] name;
        logic [1:0]   op;
        logic [31:0]  addr;
        word_t        wdata;
        strb_t        wstrb;
        word_t        exp_data;
        logic         evict;
        logic [31:0]  wb_addr;
        word_t        wb_word;
    } test_t;

    logic       CLK;
    logic       RST;
    cpu_req_t   req;
    logic       addr_valid;
    logic       cache_ready;
    word_t      data;
    logic       addr_to_l2_valid;
    line_addr_t addr_to_l2;
    line_t      data_from_l2;
    logic       data_from_l2_valid;
    logic       wb_valid;
    wb_req_t    wb;
    logic       write_done;

    test_t      cur;
    test_t      tests[$];
    int         done_count;
    int         error_count;
    int         cycle_limit;
    logic       loaded;
    line_t      l2_mem [line_addr_t];

    dcache_top uut (
        .CLK(CLK), .RST(RST), .req(req), .addr_valid(addr_valid),
        .cache_ready(cache_ready), .data(data),
        .addr_to_l2_valid(addr_to_l2_valid), .addr_to_l2(addr_to_l2),
        .data_from_l2(data_from_l2), .data_from_l2_valid(data_from_l2_valid),
        .wb_valid(wb_valid), .wb(wb), .write_done(write_done));

    dcache_checker chk (
        .CLK(CLK), .RST(RST), .req(req), .addr_valid(addr_valid),
        .cache_ready(cache_ready), .data(data), .wb_valid(wb_valid), .wb(wb),
        .test_name(cur.name), .exp_data(cur.exp_data), .exp_evict(cur.evict),
        .exp_wb_addr(cur.wb_addr), .exp_wb_word(cur.wb_word),
        .done_count(done_count), .error_count(error_count));

    // an L2 word never written starts as its byte address XOR PATTERN_KEY
    function automatic line_t l2_read(line_addr_t la);
        line_t       l;
        logic [31:0] a;
        if (l2_mem.exists(la)) begin
            l = l2_mem[la];
        end else begin
            for (int w = 0; w < `DC_WORDS; w++) begin
                a = {la, {`DC_OFFSET_W{1'b0}}} + 32'(w * 8);
                l[w*`DC_WORD_W +: `DC_WORD_W] = {32'd0, a} ^ PATTERN_KEY;
            end
        end
        return l;
    endfunction

    task automatic load_tests();
        int           fd;
        int           n;
        string        text;
        logic [127:0] nm;
        logic [1:0]   op;
        logic [31:0]  ad;
        word_t        wd;
        strb_t        ws;
        word_t        ex;
        logic         ev;
        logic [31:0]  wa;
        word_t        ww;
        fd = $fopen("dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dcache_testdata.txt, there is nothing to run");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                n = $sscanf(text, "%s %h %h %h %h %h %h %h %h", nm, op, ad, wd, ws, ex, ev, wa, ww);
                if (n == 9) begin
                    tests.push_back('{nm, op, ad, wd, ws, ex, ev, wa, ww});   // comments scan short
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue(input test_t t);
        cur        = t;
        req.op     = op_e'(t.op);
        req.addr   = addr_fields_t'(t.addr);
        req.wdata  = t.wdata;
        req.wstrb  = t.wstrb;
        addr_valid = 1'b1;
        do begin
            @(negedge CLK);
        end while (!cache_ready);   // held until the cache can take it
        @(posedge CLK);
        #DRIVE_DLY;
    endtask

    initial begin : clock
        CLK = 1'b0;
        forever begin
            #CLK_HALF CLK = ~CLK;
        end
    end

    // refill answered 4 cycles after the request pulse
    initial begin : l2_refill
        line_addr_t la;
        data_from_l2       = '0;
        data_from_l2_valid = 1'b0;
        forever begin
            @(negedge CLK);
            if (addr_to_l2_valid === 1'b1) begin
                la = addr_to_l2;
                repeat (4) @(posedge CLK);
                #DRIVE_DLY;
                data_from_l2       = l2_read(la);
                data_from_l2_valid = 1'b1;
                @(posedge CLK);
                #DRIVE_DLY;
                data_from_l2_valid = 1'b0;
            end
        end
    end

    // write-back stored at once, acknowledged 3 cycles later
    initial begin : l2_write
        write_done = 1'b0;
        forever begin
            @(negedge CLK);
            if (wb_valid === 1'b1) begin
                l2_mem[wb.addr] = wb.data;
                repeat (3) @(posedge CLK);
                #DRIVE_DLY;
                write_done = 1'b1;
                @(posedge CLK);
                #DRIVE_DLY;
                write_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (loaded);
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout after %0d cycles, test %0s never got its response", cycles, cur.name);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        RST        = 1'b1;
        req        = '0;
        addr_valid = 1'b0;
        cur        = '0;
        loaded     = 1'b0;
        load_tests();
        cycle_limit = tests.size() * 20 + 10;
        loaded      = 1'b1;
        repeat (5) @(posedge CLK);
        #DRIVE_DLY;
        RST = 1'b0;
        foreach (tests[i]) begin
            issue(tests[i]);
        end
        addr_valid = 1'b0;
        req.op     = op_none;
        while (done_count < tests.size()) begin
            @(posedge CLK);
        end
        $display("tests run %0d, errors %0d", done_count, error_count);
        if (error_count == 0 && tests.size() > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
